//--- logic/memctrl_macros.svh
`ifndef MEMCTRL_MACROS_SVH
`define MEMCTRL_MACROS_SVH

`default_nettype none

// Number of cache SRAMs behind the engine
`define NUM_CACHES 2

// Word address width of each cache SRAM
`define CACHE_AW 10

// Words per block transfer, fixed per cache
`define LEN_CACHE0 64
`define LEN_CACHE1 128

// Turnaround after the header on a read from external memory,
// counted in cycles before the output enable drops
`define EXT_WAIT 3

`default_nettype wire

`endif

//--- logic/memCtrlPkg.sv
`default_nettype none

package memCtrlPkg;

    // Transfer commands
    typedef enum logic [1:0] {
        MEMC_NONE         = 2'd0,
        MEMC_CACHE_TO_EXT = 2'd1,
        MEMC_EXT_TO_CACHE = 2'd2
    } memCmd;

    // One word on the external bus.
    // The first word of a transfer is a header, all later words are data
    typedef union packed {
        struct packed {
            logic        isWrite;
            logic        cacheId;
            logic [29:0] extAddr;
        } header;
        logic [31:0] raw;
    } extWord;

endpackage

`default_nettype wire

//--- logic/cacheStream.sv
`timescale 1ns/1ps
`include "memctrl_macros.svh"
`default_nettype none

module cacheStream (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire                                   start,
    input  wire                                   isWrite,
    input  wire  [$clog2(`NUM_CACHES)-1:0]        cacheSel,
    input  wire  [`CACHE_AW-1:0]                  len,
    input  wire  [`CACHE_AW-1:0]                  baseAddr,
    input  wire                                   finish,
    input  wire                                   rxBeat,
    input  wire  [31:0]                           rxData,
    output logic [`NUM_CACHES-1:0]                cacheCe,
    output logic [`NUM_CACHES-1:0]                cacheWe,
    output logic [`NUM_CACHES-1:0][`CACHE_AW-1:0] cacheAddr,
    output logic [`NUM_CACHES-1:0][31:0]          cacheWdata,
    output logic                                  rdValid,
    output logic [31:0]                           rdData,
    input  wire  [`NUM_CACHES-1:0][31:0]          cacheRdata
);

    logic                           active;
    logic [$clog2(`NUM_CACHES)-1:0] selQ;
    logic                           ceQ;
    logic                           weQ;
    logic [`CACHE_AW-1:0]           addrQ;
    logic [`CACHE_AW-1:0]           nextAddr;
    logic [31:0]                    wdataQ;
    logic [`CACHE_AW-1:0]           issued;

    // Only the selected cache sees strobes
    always_comb begin
        for (int i = 0; i < `NUM_CACHES; i++) begin
            cacheCe[i]    = ceQ && (selQ == i);
            cacheWe[i]    = weQ && (selQ == i);
            cacheAddr[i]  = addrQ;
            cacheWdata[i] = wdataQ;
        end
    end

    // SRAM output is valid one cycle after a read strobe
    assign rdData = cacheRdata[selQ];

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            selQ    <= '0;
            ceQ     <= 1'b0;
            weQ     <= 1'b0;
            issued  <= '0;
            rdValid <= 1'b0;
        end else begin
            rdValid <= ceQ && !weQ;
            if (start) begin
                active <= 1'b1;
                selQ   <= cacheSel;
                weQ    <= 1'b0;
                addrQ  <= baseAddr;
                if (isWrite) begin
                    // First read goes out right away
                    ceQ      <= 1'b1;
                    nextAddr <= baseAddr + 1'b1;
                    issued   <= `CACHE_AW'(1);
                end else begin
                    ceQ      <= 1'b0;
                    nextAddr <= baseAddr;
                    issued   <= '0;
                end
            end else if (active && isWrite) begin
                if (issued < len) begin
                    ceQ      <= 1'b1;
                    addrQ    <= nextAddr;
                    nextAddr <= nextAddr + 1'b1;
                    issued   <= issued + 1'b1;
                end else begin
                    ceQ <= 1'b0;
                end
            end else if (active && rxBeat) begin
                ceQ      <= 1'b1;
                weQ      <= 1'b1;
                addrQ    <= nextAddr;
                nextAddr <= nextAddr + 1'b1;
                wdataQ   <= rxData;
            end else begin
                ceQ <= 1'b0;
                weQ <= 1'b0;
            end
            if (finish) begin
                active <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/extBusPort.sv
`timescale 1ns/1ps
`include "memctrl_macros.svh"
`default_nettype none

module extBusPort (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            start,
    input  wire                            isWrite,
    input  wire  [$clog2(`NUM_CACHES)-1:0] cacheSel,
    input  wire  [29:0]                    extAddr,
    input  wire                            finish,
    input  wire                            rdValid,
    input  wire  [31:0]                    rdData,
    output logic                           extEn,
    output logic                           extOen,
    output logic [31:0]                    extBusOut,
    output logic                           rxBeat,
    output logic [31:0]                    rxData,
    input  wire  [31:0]                    extBusIn
);

    localparam logic [2:0] PIdle  = 3'd0;
    localparam logic [2:0] PWait  = 3'd1;
    localparam logic [2:0] PRecv  = 3'd2;
    localparam logic [2:0] PSend  = 3'd3;
    localparam logic [2:0] PClose = 3'd4;

    localparam int WaitW = $clog2(`EXT_WAIT + 1);

    logic [2:0]          state;
    logic [WaitW-1:0]    waitCnt;
    memCtrlPkg::extWord  header;

    always_comb begin
        header.header.isWrite = isWrite;
        header.header.cacheId = cacheSel;
        header.header.extAddr = extAddr;
    end

    // Memory drives one word per cycle while the output enable is low
    assign rxBeat = extEn && !extOen;
    assign rxData = extBusIn;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= PIdle;
            waitCnt   <= '0;
            extEn     <= 1'b0;
            extOen    <= 1'b1;
            extBusOut <= '0;
        end else begin
            case (state)
                PIdle: begin
                    if (start) begin
                        extEn     <= 1'b1;
                        extOen    <= 1'b1;
                        extBusOut <= header.raw;
                        waitCnt   <= WaitW'(`EXT_WAIT);
                        state     <= isWrite ? PSend : PWait;
                    end
                end
                // Turnaround before the memory takes the bus
                PWait: begin
                    if (waitCnt == '0) begin
                        extOen <= 1'b0;
                        state  <= PRecv;
                    end else begin
                        waitCnt <= waitCnt - 1'b1;
                    end
                end
                PRecv: begin
                    if (finish) begin
                        extOen <= 1'b1;
                        state  <= PClose;
                    end
                end
                // Header stays up until the first data word replaces it
                PSend: begin
                    if (rdValid) begin
                        extBusOut <= rdData;
                    end
                    if (finish) begin
                        state <= PClose;
                    end
                end
                PClose: begin
                    extEn     <= 1'b0;
                    extBusOut <= '0;
                    state     <= PIdle;
                end
                default: begin
                    state <= PIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/transferCtrl.sv
`timescale 1ns/1ps
`include "memctrl_macros.svh"
`default_nettype none

module transferCtrl (
    input  wire                            clk,
    input  wire                            rst,
    input  wire  memCtrlPkg::memCmd        cmd,
    input  wire  [$clog2(`NUM_CACHES)-1:0] cmdCache,
    input  wire  [`CACHE_AW-1:0]           cmdSramAddr,
    input  wire  [29:0]                    cmdExtAddr,
    output logic                           busy,
    output logic [7:0]                     progress,
    output logic [$clog2(`NUM_CACHES)-1:0] statCache,
    output logic [`NUM_CACHES-1:0]         cacheUsed,
    output logic                           start,
    output logic                           isWrite,
    output logic [$clog2(`NUM_CACHES)-1:0] cacheSel,
    output logic [`CACHE_AW-1:0]           len,
    output logic [`CACHE_AW-1:0]           baseAddr,
    output logic [29:0]                    extAddr,
    output logic                           finish,
    input  wire                            rxBeat,
    input  wire                            rdValid
);

    localparam logic [1:0] SIdle = 2'd0;
    localparam logic [1:0] SRun  = 2'd1;
    localparam logic [1:0] SDone = 2'd2;

    localparam logic [`CACHE_AW-1:0] Len0 = `LEN_CACHE0;
    localparam logic [`CACHE_AW-1:0] Len1 = `LEN_CACHE1;

    logic [1:0]           state;
    logic                 isWriteQ;
    logic [`CACHE_AW-1:0] lenQ;
    logic [`CACHE_AW-1:0] beatCnt;
    logic                 cmdIsWrite;
    logic [`CACHE_AW-1:0] cmdLen;
    logic                 beat;

    assign cmdIsWrite = (cmd == memCtrlPkg::MEMC_CACHE_TO_EXT);
    assign cmdLen     = (cmdCache == '0) ? Len0 : Len1;

    assign busy  = (state != SIdle);
    assign start = !busy && (cmd != memCtrlPkg::MEMC_NONE);

    // Engines see the command in the accept cycle, held values after it
    assign isWrite  = start ? cmdIsWrite : isWriteQ;
    assign cacheSel = start ? cmdCache : statCache;
    assign len      = start ? cmdLen : lenQ;
    assign baseAddr = cmdSramAddr;
    assign extAddr  = cmdExtAddr;

    // Writes count realigned SRAM words, reads count bus beats
    assign beat   = isWriteQ ? rdValid : rxBeat;
    assign finish = (state == SRun) && beat && (beatCnt == lenQ - 1'b1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= SIdle;
            statCache <= '0;
            cacheUsed <= '0;
            progress  <= '0;
            beatCnt   <= '0;
        end else begin
            case (state)
                SIdle: begin
                    if (start) begin
                        state               <= SRun;
                        isWriteQ            <= cmdIsWrite;
                        lenQ                <= cmdLen;
                        statCache           <= cmdCache;
                        cacheUsed           <= '0;
                        cacheUsed[cmdCache] <= 1'b1;
                        beatCnt             <= '0;
                        progress            <= '0;
                    end
                end
                SRun: begin
                    if (beat) begin
                        beatCnt <= beatCnt + 1'b1;
                        if (!isWriteQ) begin
                            progress <= progress + 1'b1;
                        end
                    end
                    if (finish) begin
                        state <= SDone;
                    end
                end
                // One closing cycle while the bus port drops its enables
                SDone: begin
                    state     <= SIdle;
                    cacheUsed <= '0;
                    progress  <= '0;
                end
                default: begin
                    state <= SIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/memSubsystem.sv
`timescale 1ns/1ps
`include "memctrl_macros.svh"
`default_nettype none

module memSubsystem (
    input  wire                                   clk,
    input  wire                                   rst,
    input  wire  memCtrlPkg::memCmd               cmd,
    input  wire  [$clog2(`NUM_CACHES)-1:0]        cmdCache,
    input  wire  [`CACHE_AW-1:0]                  cmdSramAddr,
    input  wire  [29:0]                           cmdExtAddr,
    output logic                                  busy,
    output logic [7:0]                            progress,
    output logic [$clog2(`NUM_CACHES)-1:0]        statCache,
    output logic [`NUM_CACHES-1:0]                cacheUsed,
    output logic [`NUM_CACHES-1:0]                cacheCe,
    output logic [`NUM_CACHES-1:0]                cacheWe,
    output logic [`NUM_CACHES-1:0][`CACHE_AW-1:0] cacheAddr,
    output logic [`NUM_CACHES-1:0][31:0]          cacheWdata,
    input  wire  [`NUM_CACHES-1:0][31:0]          cacheRdata,
    output logic                                  extEn,
    output logic                                  extOen,
    output logic [31:0]                           extBusOut,
    input  wire  [31:0]                           extBusIn
);

    logic                           start;
    logic                           isWrite;
    logic [$clog2(`NUM_CACHES)-1:0] cacheSel;
    logic [`CACHE_AW-1:0]           len;
    logic [`CACHE_AW-1:0]           baseAddr;
    logic [29:0]                    extAddr;
    logic                           finish;
    logic                           rxBeat;
    logic [31:0]                    rxData;
    logic                           rdValid;
    logic [31:0]                    rdData;

    transferCtrl transferCtrl_inst (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmdCache    (cmdCache),
        .cmdSramAddr (cmdSramAddr),
        .cmdExtAddr  (cmdExtAddr),
        .busy        (busy),
        .progress    (progress),
        .statCache   (statCache),
        .cacheUsed   (cacheUsed),
        .start       (start),
        .isWrite     (isWrite),
        .cacheSel    (cacheSel),
        .len         (len),
        .baseAddr    (baseAddr),
        .extAddr     (extAddr),
        .finish      (finish),
        .rxBeat      (rxBeat),
        .rdValid     (rdValid)
    );

    // SRAM side
    cacheStream cacheStream_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .isWrite    (isWrite),
        .cacheSel   (cacheSel),
        .len        (len),
        .baseAddr   (baseAddr),
        .finish     (finish),
        .rxBeat     (rxBeat),
        .rxData     (rxData),
        .cacheCe    (cacheCe),
        .cacheWe    (cacheWe),
        .cacheAddr  (cacheAddr),
        .cacheWdata (cacheWdata),
        .rdValid    (rdValid),
        .rdData     (rdData),
        .cacheRdata (cacheRdata)
    );

    // External bus side
    extBusPort extBusPort_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .isWrite   (isWrite),
        .cacheSel  (cacheSel),
        .extAddr   (extAddr),
        .finish    (finish),
        .rdValid   (rdValid),
        .rdData    (rdData),
        .extEn     (extEn),
        .extOen    (extOen),
        .extBusOut (extBusOut),
        .rxBeat    (rxBeat),
        .rxData    (rxData),
        .extBusIn  (extBusIn)
    );

endmodule

`default_nettype wire

//--- verif/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter real PeriodNs    = 4.0,
    parameter int  ResetCycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PeriodNs / 2.0) clk = ~clk;
        end
    end

    // Reset released on a falling edge like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/extMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module extMemModel (
    input  wire         clk,
    input  wire         rst,
    input  wire         extEn,
    input  wire         extOen,
    input  wire  [31:0] extBusOut,
    output logic [31:0] extBusIn
);

    memCtrlPkg::extWord hdr;
    logic               hdrSeen;
    logic               gap;
    logic [29:0]        beat;
    logic [31:0]        wrBeats[$];

    function automatic logic [31:0] patternAt(input logic [29:0] a);
        return (32'(a) * 32'h9E3779B1) ^ 32'h5A5A0000;
    endfunction

    // Read data follows the output enable with no latency
    assign extBusIn = (extEn === 1'b1 && extOen === 1'b0) ?
                      patternAt(hdr.header.extAddr + beat) : '0;

    always @(posedge clk) begin
        if (rst || !extEn) begin
            hdrSeen <= 1'b0;
            beat    <= '0;
        end else if (!hdrSeen) begin
            hdr.raw <= extBusOut;
            hdrSeen <= 1'b1;
            gap     <= 1'b1;
            wrBeats.delete();
        end else if (hdr.header.isWrite) begin
            // Header stays on the bus one more cycle before the first data word
            if (gap) begin
                gap <= 1'b0;
            end else begin
                wrBeats.push_back(extBusOut);
            end
        end else if (!extOen) begin
            beat <= beat + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verif/memSubsystem_props.sv
`timescale 1ns/1ps
`include "memctrl_macros.svh"
`default_nettype none

module memSubsystem_props (
    input wire                            clk,
    input wire                            rst,
    input wire memCtrlPkg::memCmd         cmd,
    input wire [$clog2(`NUM_CACHES)-1:0]  cmdCache,
    input wire [29:0]                     cmdExtAddr,
    input wire                            busy,
    input wire [7:0]                      progress,
    input wire [$clog2(`NUM_CACHES)-1:0]  statCache,
    input wire [`NUM_CACHES-1:0]          cacheUsed,
    input wire [`NUM_CACHES-1:0]          cacheCe,
    input wire [`NUM_CACHES-1:0]          cacheWe,
    input wire                            extEn,
    input wire                            extOen,
    input wire [31:0]                     extBusOut
);

    int unsigned                    failCount = 0;
    logic                           accept;
    logic                           acceptWr;
    logic                           acceptRd;
    logic [$clog2(`NUM_CACHES)-1:0] usedCache;

    task automatic noteFailure(input string what);
        $error("%s", what);
        failCount++;
    endtask

    assign accept   = !rst && !busy && (cmd != memCtrlPkg::MEMC_NONE);
    assign acceptWr = accept && (cmd == memCtrlPkg::MEMC_CACHE_TO_EXT);
    assign acceptRd = accept && (cmd == memCtrlPkg::MEMC_EXT_TO_CACHE);

    always_ff @(posedge clk) begin
        if (accept) begin
            usedCache <= cmdCache;
        end
    end

    resetState: assert property (@(posedge clk)
        rst |=> (!busy && !extEn && extOen && extBusOut == '0 && cacheUsed == '0
                 && cacheCe == '0 && cacheWe == '0 && progress == '0))
        else noteFailure("Outputs not at their reset values");

    idleQuiet: assert property (@(posedge clk) disable iff (rst)
        (!busy && cmd == memCtrlPkg::MEMC_NONE) |=> (!busy && !extEn && cacheCe == '0))
        else noteFailure("Engine moved without a command");

    headerWord: assert property (@(posedge clk) disable iff (rst)
        accept |=> extEn && extBusOut == {($past(cmd) == memCtrlPkg::MEMC_CACHE_TO_EXT),
                                          $past(cmdCache), $past(cmdExtAddr)})
        else noteFailure("Header word wrong one cycle after accept");

    busyIgnore: assert property (@(posedge clk) disable iff (rst)
        (busy && cmd != memCtrlPkg::MEMC_NONE) |=> $stable(statCache) && !$rose(extEn))
        else noteFailure("Command taken while busy");

    for (genvar c = 0; c < `NUM_CACHES; c++) begin : perCache
        localparam int Len = (c == 0) ? `LEN_CACHE0 : `LEN_CACHE1;

        writeTiming: assert property (@(posedge clk) disable iff (rst)
            (acceptWr && cmdCache == c) |=> (busy && extEn && extOen)[*(Len + 2)]
                ##1 (!busy && !extEn))
            else noteFailure("Write transfer did not end len+3 cycles after accept");

        // Turnaround, len beats with the output enable low, then one closing cycle
        readTiming: assert property (@(posedge clk) disable iff (rst)
            (acceptRd && cmdCache == c) |=> (busy && extEn && extOen)[*(`EXT_WAIT + 1)]
                ##1 (busy && extEn && !extOen)[*Len] ##1 (busy && extEn && extOen)
                ##1 (!busy && !extEn))
            else noteFailure("Read transfer output enable timing wrong");
    end

    usedBusy: assert property (@(posedge clk) disable iff (rst)
        busy |-> cacheUsed == (`NUM_CACHES'(1) << usedCache))
        else noteFailure("Cache-used mask not one-hot of the addressed cache");

    idleStatus: assert property (@(posedge clk) disable iff (rst)
        !busy |-> (cacheUsed == '0 && progress == '0))
        else noteFailure("Status not cleared while idle");

    progressStep: assert property (@(posedge clk) disable iff (rst)
        (busy && extEn && !extOen) |=> progress == $past(progress) + 8'd1)
        else noteFailure("Progress did not count a read beat");

    progressHold: assert property (@(posedge clk) disable iff (rst)
        (busy && extOen) |=> (progress == $past(progress)) || !busy)
        else noteFailure("Progress moved without a read beat");

endmodule

`default_nettype wire

//--- verif/memSubsystemTb.sv
`timescale 1ns/1ps
`include "memctrl_macros.svh"
`default_nettype none

module memSubsystemTb;

    localparam int  NumTransfers      = 8;
    localparam int  CyclesPerTransfer = 200;
    localparam int  ResetCycles       = 16;
    localparam real ClkPeriod         = 4.0;
    localparam int  Depth             = 1 << `CACHE_AW;

    logic                                  clk;
    logic                                  rst;
    memCtrlPkg::memCmd                     cmd;
    logic [$clog2(`NUM_CACHES)-1:0]        cmdCache;
    logic [`CACHE_AW-1:0]                  cmdSramAddr;
    logic [29:0]                           cmdExtAddr;
    logic                                  busy;
    logic [7:0]                            progress;
    logic [$clog2(`NUM_CACHES)-1:0]        statCache;
    logic [`NUM_CACHES-1:0]                cacheUsed;
    logic [`NUM_CACHES-1:0]                cacheCe;
    logic [`NUM_CACHES-1:0]                cacheWe;
    logic [`NUM_CACHES-1:0][`CACHE_AW-1:0] cacheAddr;
    logic [`NUM_CACHES-1:0][31:0]          cacheWdata;
    logic [`NUM_CACHES-1:0][31:0]          cacheRdata = '0;
    logic                                  extEn;
    logic                                  extOen;
    logic [31:0]                           extBusOut;
    logic [31:0]                           extBusIn;

    logic [31:0]          sramMem [`NUM_CACHES][Depth];
    logic [31:0]          refMem [`NUM_CACHES][Depth];
    int                   wrCacheLog[$];
    logic [`CACHE_AW-1:0] wrAddrLog[$];
    logic [31:0]          wrDataLog[$];
    integer               seed;

    tbClock #(.PeriodNs(ClkPeriod), .ResetCycles(ResetCycles)) tbClock_inst (
        .clk (clk),
        .rst (rst)
    );

    memSubsystem memSubsystem_inst (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .cmdCache    (cmdCache),
        .cmdSramAddr (cmdSramAddr),
        .cmdExtAddr  (cmdExtAddr),
        .busy        (busy),
        .progress    (progress),
        .statCache   (statCache),
        .cacheUsed   (cacheUsed),
        .cacheCe     (cacheCe),
        .cacheWe     (cacheWe),
        .cacheAddr   (cacheAddr),
        .cacheWdata  (cacheWdata),
        .cacheRdata  (cacheRdata),
        .extEn       (extEn),
        .extOen      (extOen),
        .extBusOut   (extBusOut),
        .extBusIn    (extBusIn)
    );

    extMemModel extMemModel_inst (
        .clk       (clk),
        .rst       (rst),
        .extEn     (extEn),
        .extOen    (extOen),
        .extBusOut (extBusOut),
        .extBusIn  (extBusIn)
    );

    bind memSubsystem memSubsystem_props memSubsystemProps_inst (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .cmdCache   (cmdCache),
        .cmdExtAddr (cmdExtAddr),
        .busy       (busy),
        .progress   (progress),
        .statCache  (statCache),
        .cacheUsed  (cacheUsed),
        .cacheCe    (cacheCe),
        .cacheWe    (cacheWe),
        .extEn      (extEn),
        .extOen     (extOen),
        .extBusOut  (extBusOut)
    );

    // Preload word of a cache SRAM
    function automatic logic [31:0] cacheFill(input int c, input int a);
        return 32'hCA000000 + (32'(c) << 24) + 32'(a) * 32'd4099;
    endfunction

    // Word external memory returns at a given address
    function automatic logic [31:0] extPattern(input logic [29:0] a);
        return (32'(a) * 32'h9E3779B1) ^ 32'h5A5A0000;
    endfunction

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic expectWord(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else stopOnError($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // Cache SRAMs with one cycle of read latency
    always @(posedge clk) begin
        for (int c = 0; c < `NUM_CACHES; c++) begin
            if (rst) begin
                cacheRdata[c] <= '0;
                for (int a = 0; a < Depth; a++) begin
                    sramMem[c][a] <= cacheFill(c, a);
                end
            end else if (cacheCe[c] && cacheWe[c]) begin
                sramMem[c][cacheAddr[c]] <= cacheWdata[c];
                wrCacheLog.push_back(c);
                wrAddrLog.push_back(cacheAddr[c]);
                wrDataLog.push_back(cacheWdata[c]);
            end else if (cacheCe[c]) begin
                cacheRdata[c] <= sramMem[c][cacheAddr[c]];
            end
        end
    end

    always @(negedge clk) begin
        if (memSubsystem_inst.memSubsystemProps_inst.failCount != 0) begin
            stopOnError("A protocol assertion on memSubsystem failed");
        end
    end

    task automatic runTransfer(input bit toExt, input int cache,
                               input logic [`CACHE_AW-1:0] sAddr, input logic [29:0] eAddr);
        int                   len;
        logic [`CACHE_AW-1:0] a;
        logic [29:0]          x;
        memCtrlPkg::extWord   expHdr;
        len = (cache == 0) ? `LEN_CACHE0 : `LEN_CACHE1;
        wrCacheLog.delete();
        wrAddrLog.delete();
        wrDataLog.delete();
        cmd         = toExt ? memCtrlPkg::MEMC_CACHE_TO_EXT : memCtrlPkg::MEMC_EXT_TO_CACHE;
        cmdCache    = cache[0];
        cmdSramAddr = sAddr;
        cmdExtAddr  = eAddr;
        @(negedge clk);
        cmd = memCtrlPkg::MEMC_NONE;
        // A second strobe in mid transfer has to be dropped
        repeat (2) @(negedge clk);
        cmd         = toExt ? memCtrlPkg::MEMC_EXT_TO_CACHE : memCtrlPkg::MEMC_CACHE_TO_EXT;
        cmdCache    = ~cmdCache;
        cmdSramAddr = `CACHE_AW'($random(seed));
        cmdExtAddr  = 30'($random(seed));
        @(negedge clk);
        cmd = memCtrlPkg::MEMC_NONE;
        while (busy) begin
            @(negedge clk);
        end
        expectWord("statCache", 32'(statCache), 32'(cache));
        expHdr.header.isWrite = toExt;
        expHdr.header.cacheId = cache[0];
        expHdr.header.extAddr = eAddr;
        expectWord("extBusOut header", extMemModel_inst.hdr.raw, expHdr.raw);
        if (toExt) begin
            expectWord("write beat count", 32'(extMemModel_inst.wrBeats.size()), 32'(len));
            for (int k = 0; k < len; k++) begin
                a = sAddr + `CACHE_AW'(k);
                expectWord($sformatf("extBusOut beat %0d", k),
                           extMemModel_inst.wrBeats[k], refMem[cache][a]);
            end
        end else begin
            expectWord("cacheWe count", 32'(wrDataLog.size()), 32'(len));
            for (int k = 0; k < len; k++) begin
                a = sAddr + `CACHE_AW'(k);
                x = eAddr + 30'(k);
                expectWord($sformatf("cacheWe target %0d", k), 32'(wrCacheLog[k]), 32'(cache));
                expectWord($sformatf("cacheAddr %0d", k), 32'(wrAddrLog[k]), 32'(a));
                expectWord($sformatf("cacheWdata %0d", k), wrDataLog[k], extPattern(x));
                refMem[cache][a] = extPattern(x);
            end
        end
    endtask

    initial begin
        int cache;
        bit toExt;
        int gap;
        seed        = 32'hda1c;
        cmd         = memCtrlPkg::MEMC_NONE;
        cmdCache    = '0;
        cmdSramAddr = '0;
        cmdExtAddr  = '0;
        for (int c = 0; c < `NUM_CACHES; c++) begin
            for (int a = 0; a < Depth; a++) begin
                refMem[c][a] = cacheFill(c, a);
            end
        end
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        assert (!busy && !extEn && extOen && cacheUsed == '0)
        else stopOnError("Engine not idle after reset");
        // Both directions on both caches first, then random caches
        for (int t = 0; t < NumTransfers; t++) begin
            toExt = (t % 2) == 0;
            cache = (t < 4) ? (t / 2) : ($random(seed) & 1);
            runTransfer(toExt, cache, `CACHE_AW'($random(seed)), 30'($random(seed)));
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
        end
        if (memSubsystem_inst.memSubsystemProps_inst.failCount == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stopOnError("A protocol assertion failed at the end of the run");
        end
    end

    initial begin
        #((ResetCycles + NumTransfers * CyclesPerTransfer) * ClkPeriod);
        stopOnError("Timeout: the transfers did not complete in time");
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+logic
logic/memCtrlPkg.sv
logic/cacheStream.sv
logic/extBusPort.sv
logic/transferCtrl.sv
logic/memSubsystem.sv
verif/tbClock.sv
verif/extMemModel.sv
verif/memSubsystem_props.sv
verif/memSubsystemTb.sv

//--- Bender.yml
package:
  name: mem_subsystem

sources:
  - include_dirs:
      - logic
    files:
      - logic/memCtrlPkg.sv
      - logic/cacheStream.sv
      - logic/extBusPort.sv
      - logic/transferCtrl.sv
      - logic/memSubsystem.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tbClock.sv
      - verif/extMemModel.sv
      - verif/memSubsystem_props.sv
      - verif/memSubsystemTb.sv
